//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	//////////////////////////////
	// Widths that carry a meaning

	typedef logic [31:0] word_t;       // Data or instruction word
	typedef logic [6:0]  pc_t;         // Instruction word address
	typedef logic [6:0]  dmem_addr_t;  // Data word address
	typedef logic [4:0]  reg_addr_t;   // Register number
	typedef logic [2:0]  alu_fn_t;     // ALU operation select

	localparam int IMEM_DEPTH = 128;   // Words, full pc_t range
	localparam int DMEM_DEPTH = 128;

	//////////////////////////////
	// Instruction encodings

	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;
	localparam logic [5:0] OP_BEQ   = 6'h04;

	localparam logic [5:0] FN_ADD = 6'h20;  // R-type funct field
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	localparam word_t NOP_INSTR = 32'h0000_0000;  // Funct 0 decodes to nothing

	localparam alu_fn_t ALU_ADD = 3'd0;
	localparam alu_fn_t ALU_SUB = 3'd1;
	localparam alu_fn_t ALU_AND = 3'd2;
	localparam alu_fn_t ALU_OR  = 3'd3;
	localparam alu_fn_t ALU_SLT = 3'd4;

	//////////////////////////////
	// Enums

	typedef enum logic [1:0] {
		FWD_NONE,      // Register file value
		FWD_EX_MEM,    // ALU result one stage ahead
		FWD_MEM_WB     // Writeback value
	} fwd_sel_t;

	typedef enum logic [1:0] {
		LOAD_IDLE,     // Ack low, waiting for req
		LOAD_WRITE,    // Word being written
		LOAD_WAIT      // Ack high until req drops
	} load_state_t;

	//////////////////////////////
	// Pipeline registers

	typedef struct packed {
		logic    reg_write;
		logic    mem_to_reg;     // Writeback takes load data
		logic    mem_write;
		logic    alu_src;        // B operand from immediate
		alu_fn_t alu_fn;
	} ctrl_t;

	typedef struct packed {
		logic  valid;
		pc_t   pc_plus1;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		logic      valid;
		ctrl_t     ctrl;
		reg_addr_t rs;             // Source regs, zero when unused
		reg_addr_t rt;
		reg_addr_t dst;
		word_t     op_a;
		word_t     op_b;
		word_t     imm;
	} id_ex_t;

	typedef struct packed {
		logic      valid;
		ctrl_t     ctrl;
		reg_addr_t dst;
		word_t     alu_result;
		word_t     store_data;
	} ex_mem_t;

	typedef struct packed {
		logic      valid;          // Register write this cycle
		reg_addr_t dst;
		word_t     data;
	} wb_t;

endpackage

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
	input  wire                    clk,
	input  wire                    rst,
	input  wire cpu_pkg::if_id_t   if_id,
	input  wire cpu_pkg::id_ex_t   ex_stage,   // ID/EX as it stands now
	input  wire cpu_pkg::ex_mem_t  ex_mem,
	input  wire cpu_pkg::wb_t      wb,         // Register file write
	output logic                   stall,
	output logic                   branch_taken,
	output cpu_pkg::pc_t           branch_target,
	output cpu_pkg::id_ex_t        id_ex
);

	cpu_pkg::word_t     regs [32];     // r0 is never written
	cpu_pkg::reg_addr_t rs;
	cpu_pkg::reg_addr_t rt;
	cpu_pkg::reg_addr_t rd;
	cpu_pkg::reg_addr_t dst;
	cpu_pkg::word_t     rd_a;
	cpu_pkg::word_t     rd_b;
	cpu_pkg::word_t     imm_ext;
	cpu_pkg::pc_t       br_off;
	cpu_pkg::ctrl_t     ctrl;
	logic [5:0]         opcode;
	logic [5:0]         funct;
	logic               is_beq;
	logic               uses_rt;       // rt is a source, not a destination
	logic               load_use;
	logic               branch_wait;

	assign opcode  = if_id.instr[31:26];
	assign rs      = if_id.instr[25:21];
	assign rt      = if_id.instr[20:16];
	assign rd      = if_id.instr[15:11];
	assign funct   = if_id.instr[5:0];
	assign imm_ext = {{16{if_id.instr[15]}}, if_id.instr[15:0]};
	assign br_off  = imm_ext[6:0];      // Word offset, wraps with the PC

	//////////////////////////////
	// Register file

	always_ff @(posedge clk) begin
		if (wb.valid) begin
			regs[wb.dst] <= wb.data;
		end
	end

	function automatic cpu_pkg::word_t read_port(cpu_pkg::reg_addr_t addr);
		if (addr == '0) return '0;
		if (wb.valid && wb.dst == addr) return wb.data;  // Write-through
		return regs[addr];
	endfunction

	always_comb begin
		rd_a = read_port(rs);
		rd_b = read_port(rt);
	end

	//////////////////////////////
	// Control decode

	always_comb begin
		ctrl    = '0;
		dst     = rt;
		is_beq  = 1'b0;
		uses_rt = 1'b0;
		case (opcode)
			cpu_pkg::OP_RTYPE: begin
				dst            = rd;
				uses_rt        = 1'b1;
				ctrl.reg_write = 1'b1;
				case (funct)
					cpu_pkg::FN_ADD: ctrl.alu_fn = cpu_pkg::ALU_ADD;
					cpu_pkg::FN_SUB: ctrl.alu_fn = cpu_pkg::ALU_SUB;
					cpu_pkg::FN_AND: ctrl.alu_fn = cpu_pkg::ALU_AND;
					cpu_pkg::FN_OR:  ctrl.alu_fn = cpu_pkg::ALU_OR;
					cpu_pkg::FN_SLT: ctrl.alu_fn = cpu_pkg::ALU_SLT;
					default:         ctrl.reg_write = 1'b0;   // NOP lands here
				endcase
			end
			cpu_pkg::OP_ADDI: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.alu_fn    = cpu_pkg::ALU_ADD;
			end
			cpu_pkg::OP_LW: begin
				ctrl.reg_write  = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.alu_src    = 1'b1;
				ctrl.alu_fn     = cpu_pkg::ALU_ADD;       // Base plus offset
			end
			cpu_pkg::OP_SW: begin
				uses_rt        = 1'b1;                    // Store data
				ctrl.mem_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.alu_fn    = cpu_pkg::ALU_ADD;
			end
			cpu_pkg::OP_BEQ: begin
				uses_rt = 1'b1;
				is_beq  = 1'b1;                           // Resolved here
			end
			default: ;
		endcase
		if (dst == '0) ctrl.reg_write = 1'b0;         // r0 stays zero
		if (!if_id.valid) begin
			ctrl   = '0;
			is_beq = 1'b0;
		end
	end

	//////////////////////////////
	// Hazards and branch

	// Load result not ready before execute needs it
	assign load_use = ex_stage.valid && ex_stage.ctrl.reg_write && ex_stage.ctrl.mem_to_reg &&
		(ex_stage.dst == rs || (uses_rt && ex_stage.dst == rt));

	// No forwarding into decode, so wait until the writer reaches writeback
	assign branch_wait = is_beq &&
		((ex_stage.valid && ex_stage.ctrl.reg_write &&
			(ex_stage.dst == rs || ex_stage.dst == rt)) ||
		(ex_mem.valid && ex_mem.ctrl.reg_write &&
			(ex_mem.dst == rs || ex_mem.dst == rt)));

	assign stall         = if_id.valid && (load_use || branch_wait);
	assign branch_taken  = is_beq && !stall && (rd_a == rd_b);
	assign branch_target = if_id.pc_plus1 + br_off;

	always_ff @(posedge clk) begin
		if (rst) begin
			id_ex.valid <= 1'b0;
			id_ex.ctrl  <= '0;
		end else if (stall) begin
			id_ex.valid <= 1'b0;                          // Bubble
			id_ex.ctrl  <= '0;
		end else begin
			id_ex.valid <= if_id.valid;
			id_ex.ctrl  <= ctrl;
		end
	end

	always_ff @(posedge clk) begin
		id_ex.rs   <= rs;
		id_ex.rt   <= uses_rt ? rt : '0;                 // Keeps addi/lw out of forwarding
		id_ex.dst  <= dst;
		id_ex.op_a <= rd_a;
		id_ex.op_b <= rd_b;
		id_ex.imm  <= imm_ext;
	end

	// Fetch squashes the slot behind a taken branch
	branch_squash: assert property (@(posedge clk) disable iff (rst)
		branch_taken |=> !if_id.valid);

	// Fetch holds IF/ID through a stall
	stall_holds_fetch: assert property (@(posedge clk) disable iff (rst)
		stall |=> $stable(if_id));

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
	input  wire                    clk,
	input  wire                    rst,
	input  wire cpu_pkg::id_ex_t   id_ex,
	input  wire cpu_pkg::wb_t      wb,        // MEM/WB forwarding source
	output cpu_pkg::ex_mem_t       ex_mem
);

	cpu_pkg::fwd_sel_t fwd_a;
	cpu_pkg::fwd_sel_t fwd_b;
	cpu_pkg::word_t    src_a;
	cpu_pkg::word_t    src_b;     // Forwarded rt, also the store data
	cpu_pkg::word_t    alu_b;
	cpu_pkg::word_t    alu_y;

	//////////////////////////////
	// Forwarding

	function automatic cpu_pkg::fwd_sel_t pick_fwd(cpu_pkg::reg_addr_t src);
		if (!id_ex.valid || src == '0) return cpu_pkg::FWD_NONE;   // r0 never forwarded
		if (ex_mem.valid && ex_mem.ctrl.reg_write && ex_mem.dst == src) begin
			return cpu_pkg::FWD_EX_MEM;                            // Youngest wins
		end
		if (wb.valid && wb.dst == src) return cpu_pkg::FWD_MEM_WB;
		return cpu_pkg::FWD_NONE;
	endfunction

	function automatic cpu_pkg::word_t fwd_mux(cpu_pkg::fwd_sel_t sel,
			cpu_pkg::word_t reg_val);
		case (sel)
			cpu_pkg::FWD_EX_MEM: return ex_mem.alu_result;
			cpu_pkg::FWD_MEM_WB: return wb.data;
			default:             return reg_val;
		endcase
	endfunction

	always_comb begin
		fwd_a = pick_fwd(id_ex.rs);
		fwd_b = pick_fwd(id_ex.rt);
		src_a = fwd_mux(fwd_a, id_ex.op_a);
		src_b = fwd_mux(fwd_b, id_ex.op_b);
	end

	//////////////////////////////
	// ALU

	assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : src_b;

	always_comb begin
		case (id_ex.ctrl.alu_fn)
			cpu_pkg::ALU_ADD: alu_y = src_a + alu_b;
			cpu_pkg::ALU_SUB: alu_y = src_a - alu_b;
			cpu_pkg::ALU_AND: alu_y = src_a & alu_b;
			cpu_pkg::ALU_OR:  alu_y = src_a | alu_b;
			cpu_pkg::ALU_SLT: alu_y = {31'b0, $signed(src_a) < $signed(alu_b)};
			default:          alu_y = src_a + alu_b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_mem.valid <= 1'b0;
			ex_mem.ctrl  <= '0;
		end else begin
			ex_mem.valid <= id_ex.valid;
			ex_mem.ctrl  <= id_ex.ctrl;
		end
	end

	always_ff @(posedge clk) begin
		ex_mem.dst        <= id_ex.dst;
		ex_mem.alu_result <= alu_y;
		ex_mem.store_data <= src_b;
	end

	// Decode's load-use stall keeps a load out of the EX/MEM bypass
	no_load_forward: assert property (@(posedge clk) disable iff (rst)
		(fwd_a == cpu_pkg::FWD_EX_MEM || fwd_b == cpu_pkg::FWD_EX_MEM) |->
			!ex_mem.ctrl.mem_to_reg);

endmodule

`default_nettype wire

//--- fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_stage (
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   enable,         // Run high, load low
	input  wire                   stall,          // Hold PC and IF/ID
	input  wire                   branch_taken,   // Redirect from decode
	input  wire cpu_pkg::pc_t     branch_target,
	input  wire                   load_req,       // Four-phase load port
	input  wire cpu_pkg::pc_t     load_addr,
	input  wire cpu_pkg::word_t   load_data,
	output logic                  load_ack,
	output cpu_pkg::if_id_t       if_id
);

	cpu_pkg::pc_t         pc;                         // Next fetch address
	cpu_pkg::word_t       imem [cpu_pkg::IMEM_DEPTH];
	cpu_pkg::load_state_t load_state;

	//////////////////////////////
	// Instruction memory loader

	always_ff @(posedge clk) begin
		if (rst) begin
			load_state <= cpu_pkg::LOAD_IDLE;
			load_ack   <= 1'b0;
		end else begin
			case (load_state)
				cpu_pkg::LOAD_IDLE: begin
					if (load_req && !enable) begin        // Only while halted
						load_state <= cpu_pkg::LOAD_WRITE;
					end
				end
				cpu_pkg::LOAD_WRITE: begin
					load_ack   <= 1'b1;                 // Word lands this edge
					load_state <= cpu_pkg::LOAD_WAIT;
				end
				cpu_pkg::LOAD_WAIT: begin
					if (!load_req) begin                  // Master let go
						load_ack   <= 1'b0;
						load_state <= cpu_pkg::LOAD_IDLE;
					end
				end
				default: load_state <= cpu_pkg::LOAD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load_state == cpu_pkg::LOAD_WRITE) begin
			imem[load_addr] <= load_data;         // Addr and data held by master
		end
	end

	//////////////////////////////
	// PC and IF/ID

	always_ff @(posedge clk) begin
		if (rst) begin
			pc          <= '0;
			if_id.valid <= 1'b0;
		end else if (branch_taken) begin
			pc          <= branch_target;
			if_id.valid <= 1'b0;                   // Squash the wrong-path word
		end else if (!stall) begin
			if (enable) begin
				pc             <= pc + 1'b1;
				if_id.valid    <= 1'b1;
				if_id.pc_plus1 <= pc + 1'b1;
				if_id.instr    <= imem[pc];
			end else begin
				if_id.valid <= 1'b0;                   // Halted, bubbles only
			end
		end
	end

	// Ack follows a req that was still up on the writing edge
	ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(load_ack) |-> $past(load_req));

	// Memory write only happens with the core halted
	no_load_when_running: assert property (@(posedge clk) disable iff (rst)
		(load_state == cpu_pkg::LOAD_WRITE) |-> !enable);

endmodule

`default_nettype wire

//--- mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage (
	input  wire                    clk,
	input  wire                    rst,
	input  wire cpu_pkg::ex_mem_t  ex_mem,
	output cpu_pkg::wb_t           wb
);

	cpu_pkg::word_t      dmem [cpu_pkg::DMEM_DEPTH];
	cpu_pkg::dmem_addr_t addr;
	cpu_pkg::word_t      load_q;       // Registered read port
	cpu_pkg::word_t      alu_q;
	cpu_pkg::reg_addr_t  dst_q;
	logic                valid_q;
	logic                to_reg_q;

	assign addr = ex_mem.alu_result[6:0];  // Word address, upper bits ignored

	//////////////////////////////
	// Data memory

	always_ff @(posedge clk) begin
		if (ex_mem.valid && ex_mem.ctrl.mem_write) begin
			dmem[addr] <= ex_mem.store_data;
		end
		load_q <= dmem[addr];
	end

	//////////////////////////////
	// MEM/WB

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= ex_mem.valid && ex_mem.ctrl.reg_write;  // Writers only
		end
	end

	always_ff @(posedge clk) begin
		dst_q    <= ex_mem.dst;
		to_reg_q <= ex_mem.ctrl.mem_to_reg;
		alu_q    <= ex_mem.alu_result;
	end

	always_comb begin
		wb.valid = valid_q;
		wb.dst   = dst_q;
		wb.data  = to_reg_q ? load_q : alu_q;   // Load or ALU result
	end

endmodule

`default_nettype wire

//--- pipeline.sv
`timescale 1ns/100ps
`default_nettype none

module pipeline (
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   enable,      // Low to load the program
	input  wire                   load_req,
	input  wire cpu_pkg::pc_t     load_addr,
	input  wire cpu_pkg::word_t   load_data,
	output wire                   load_ack,
	output wire cpu_pkg::wb_t     retire       // One pulse per register write
);

	wire cpu_pkg::if_id_t  if_id;
	wire cpu_pkg::id_ex_t  id_ex;
	wire cpu_pkg::ex_mem_t ex_mem;
	wire cpu_pkg::wb_t     wb;
	wire cpu_pkg::pc_t     branch_target;
	wire                   stall;
	wire                   branch_taken;

	//////////////////////////////
	// Stages

	fetch_stage fetch_inst (
		.clk           (clk),
		.rst           (rst),
		.enable        (enable),
		.stall         (stall),          // From hazard logic
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.load_req      (load_req),
		.load_addr     (load_addr),
		.load_data     (load_data),
		.load_ack      (load_ack),
		.if_id         (if_id)
	);

	decode_stage decode_inst (
		.clk           (clk),
		.rst           (rst),
		.if_id         (if_id),
		.ex_stage      (id_ex),          // Own output, for hazards
		.ex_mem        (ex_mem),
		.wb            (wb),
		.stall         (stall),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.id_ex         (id_ex)
	);

	execute_stage execute_inst (
		.clk    (clk),
		.rst    (rst),
		.id_ex  (id_ex),
		.wb     (wb),
		.ex_mem (ex_mem)
	);

	mem_stage mem_inst (
		.clk    (clk),
		.rst    (rst),
		.ex_mem (ex_mem),
		.wb     (wb)
	);

	assign retire = wb;   // Writeback seen from outside

endmodule

`default_nettype wire

//--- project.f
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_stage.sv
pipeline.sv
tb_pipeline.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0") " 2>/dev/null || cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_pipeline \
	-f project.f -o sim_tb_pipeline \
	&& ./obj_dir/sim_tb_pipeline > sim.log 2>&1 \
	|| echo "Verilator build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "^TESTBENCH PASSED$" sim.log 2>/dev/null && exit 0 || exit 1

//--- tb_pipeline.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pipeline;

	localparam int CLK_PERIOD  = 20;
	localparam int N_PROGS     = 5;
	localparam int ACK_LIMIT   = 16;      // Cycles allowed per ack edge
	localparam int TAIL_CYCLES = 20;      // Quiet window after last retire

	typedef struct packed {
		logic [2:0]         prog;        // Program number
		cpu_pkg::word_t     instr;
		logic               ret;         // Expected to retire
		cpu_pkg::reg_addr_t dst;
		cpu_pkg::word_t     val;
	} row_t;

	logic              clk;
	logic              rst;
	logic              enable;
	logic              load_req;
	cpu_pkg::pc_t      load_addr;
	cpu_pkg::word_t    load_data;
	wire               load_ack;
	wire cpu_pkg::wb_t retire;

	row_t rows [$];                    // All programs, in program order
	logic table_ready = 1'b0;
	int   errors;
	int   checks;
	int   tests_run;
	int   tests_passed;

	pipeline pipeline_inst (
		.clk       (clk),
		.rst       (rst),
		.enable    (enable),
		.load_req  (load_req),
		.load_addr (load_addr),
		.load_data (load_data),
		.load_ack  (load_ack),
		.retire    (retire)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Budget grows with table size plus full memory loads
	initial begin
		int limit_cycles;
		wait (table_ready === 1'b1);
		limit_cycles = rows.size() * 200 + N_PROGS * (cpu_pkg::IMEM_DEPTH * 8 + 40) + 100;
		#(limit_cycles * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", limit_cycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

	//////////////////////////////
	// Encoders and table

	function automatic cpu_pkg::word_t r_type(int rd, int rs, int rt, logic [5:0] fn);
		return {cpu_pkg::OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
	endfunction

	// rt is the destination or store data, rs the base or first source
	function automatic cpu_pkg::word_t i_type(logic [5:0] op, int rt, int rs, int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic cpu_pkg::word_t xorshift32(cpu_pkg::word_t x);
		cpu_pkg::word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic void add_row(int prog, cpu_pkg::word_t instr, logic ret, int dst,
			cpu_pkg::word_t val);
		row_t r;
		r.prog  = prog[2:0];
		r.instr = instr;
		r.ret   = ret;
		r.dst   = dst[4:0];
		r.val   = val;
		rows.push_back(r);
	endfunction

	function automatic void build_table();
		cpu_pkg::word_t state;
		cpu_pkg::word_t acc;
		int             dst;
		int             src;
		int             k;
		// Independent ALU ops, r0 writes stay silent
		add_row(0, i_type(cpu_pkg::OP_ADDI, 1, 0, 25), 1'b1, 1, 32'd25);
		add_row(0, i_type(cpu_pkg::OP_ADDI, 2, 0, -7), 1'b1, 2, 32'hffff_fff9);
		add_row(0, i_type(cpu_pkg::OP_ADDI, 3, 0, 12), 1'b1, 3, 32'd12);
		add_row(0, i_type(cpu_pkg::OP_ADDI, 4, 0, 10), 1'b1, 4, 32'd10);
		add_row(0, r_type(5, 1, 2, cpu_pkg::FN_ADD), 1'b1, 5, 32'd18);
		add_row(0, r_type(6, 3, 4, cpu_pkg::FN_SUB), 1'b1, 6, 32'd2);
		add_row(0, r_type(7, 1, 3, cpu_pkg::FN_AND), 1'b1, 7, 32'd8);   // 11001 & 01100
		add_row(0, r_type(8, 1, 3, cpu_pkg::FN_OR), 1'b1, 8, 32'd29);
		add_row(0, r_type(9, 2, 1, cpu_pkg::FN_SLT), 1'b1, 9, 32'd1);   // Signed compare
		add_row(0, r_type(10, 1, 2, cpu_pkg::FN_SLT), 1'b1, 10, 32'd0);
		add_row(0, i_type(cpu_pkg::OP_ADDI, 0, 1, 5), 1'b0, 0, 32'd0);
		add_row(0, r_type(0, 1, 2, cpu_pkg::FN_ADD), 1'b0, 0, 32'd0);
		add_row(0, r_type(11, 2, 1, cpu_pkg::FN_SUB), 1'b1, 11, 32'hffff_ffe0);
		// Chained addi with pseudo-random immediates
		state = 32'd79;
		acc   = '0;
		src   = 0;
		for (k = 0; k < 8; k++) begin
			state = xorshift32(state);
			dst   = 1 + k % 6;
			acc   = acc + {{16{state[15]}}, state[15:0]};   // Wraps at 32 bits
			add_row(1, i_type(cpu_pkg::OP_ADDI, dst, src, int'(state[15:0])), 1'b1, dst, acc);
			src   = dst;
		end
		// Back-to-back dependencies
		add_row(2, i_type(cpu_pkg::OP_ADDI, 1, 0, 3), 1'b1, 1, 32'd3);
		add_row(2, r_type(2, 1, 1, cpu_pkg::FN_ADD), 1'b1, 2, 32'd6);
		add_row(2, r_type(3, 2, 1, cpu_pkg::FN_ADD), 1'b1, 3, 32'd9);
		add_row(2, r_type(4, 3, 2, cpu_pkg::FN_SUB), 1'b1, 4, 32'd3);
		add_row(2, r_type(5, 4, 3, cpu_pkg::FN_OR), 1'b1, 5, 32'd11);
		add_row(2, r_type(6, 5, 3, cpu_pkg::FN_AND), 1'b1, 6, 32'd9);
		add_row(2, r_type(7, 4, 6, cpu_pkg::FN_SLT), 1'b1, 7, 32'd1);
		add_row(2, i_type(cpu_pkg::OP_ADDI, 1, 1, 100), 1'b1, 1, 32'd103);
		add_row(2, r_type(8, 1, 7, cpu_pkg::FN_ADD), 1'b1, 8, 32'd104);
		add_row(2, i_type(cpu_pkg::OP_ADDI, 10, 0, 1), 1'b1, 10, 32'd1);
		add_row(2, i_type(cpu_pkg::OP_ADDI, 10, 0, 2), 1'b1, 10, 32'd2);
		add_row(2, r_type(11, 10, 10, cpu_pkg::FN_ADD), 1'b1, 11, 32'd4);  // Youngest r10
		add_row(2, r_type(12, 11, 8, cpu_pkg::FN_SUB), 1'b1, 12, 32'hffff_ff9c);
		// Stores, loads and load-use
		add_row(3, i_type(cpu_pkg::OP_ADDI, 1, 0, 20), 1'b1, 1, 32'd20);
		add_row(3, i_type(cpu_pkg::OP_ADDI, 2, 0, 'h1234), 1'b1, 2, 32'h1234);
		add_row(3, i_type(cpu_pkg::OP_SW, 2, 1, 4), 1'b0, 0, 32'd0);       // mem[24]
		add_row(3, i_type(cpu_pkg::OP_LW, 3, 1, 4), 1'b1, 3, 32'h1234);
		add_row(3, r_type(4, 3, 3, cpu_pkg::FN_ADD), 1'b1, 4, 32'h2468);
		add_row(3, i_type(cpu_pkg::OP_ADDI, 5, 0, -1), 1'b1, 5, 32'hffff_ffff);
		add_row(3, i_type(cpu_pkg::OP_SW, 5, 1, 0), 1'b0, 0, 32'd0);       // mem[20]
		add_row(3, i_type(cpu_pkg::OP_SW, 4, 1, 1), 1'b0, 0, 32'd0);       // mem[21]
		add_row(3, i_type(cpu_pkg::OP_LW, 6, 1, 0), 1'b1, 6, 32'hffff_ffff);
		add_row(3, i_type(cpu_pkg::OP_LW, 7, 1, 1), 1'b1, 7, 32'h2468);
		add_row(3, r_type(8, 7, 6, cpu_pkg::FN_SUB), 1'b1, 8, 32'h2469);
		add_row(3, i_type(cpu_pkg::OP_LW, 9, 1, 4), 1'b1, 9, 32'h1234);
		// Taken and not-taken beq
		add_row(4, i_type(cpu_pkg::OP_ADDI, 1, 0, 5), 1'b1, 1, 32'd5);
		add_row(4, i_type(cpu_pkg::OP_ADDI, 2, 0, 5), 1'b1, 2, 32'd5);
		add_row(4, i_type(cpu_pkg::OP_BEQ, 2, 1, 1), 1'b0, 0, 32'd0);      // Taken
		add_row(4, i_type(cpu_pkg::OP_ADDI, 3, 0, 111), 1'b0, 3, 32'd111);
		add_row(4, i_type(cpu_pkg::OP_ADDI, 4, 0, 44), 1'b1, 4, 32'd44);
		add_row(4, i_type(cpu_pkg::OP_BEQ, 4, 1, 1), 1'b0, 0, 32'd0);      // Not taken
		add_row(4, i_type(cpu_pkg::OP_ADDI, 5, 0, 55), 1'b1, 5, 32'd55);
		add_row(4, i_type(cpu_pkg::OP_BEQ, 0, 0, 2), 1'b0, 0, 32'd0);      // Skips two
		add_row(4, i_type(cpu_pkg::OP_ADDI, 6, 0, 66), 1'b0, 6, 32'd66);
		add_row(4, i_type(cpu_pkg::OP_ADDI, 7, 0, 77), 1'b0, 7, 32'd77);
		add_row(4, r_type(8, 1, 4, cpu_pkg::FN_ADD), 1'b1, 8, 32'd49);
		add_row(4, i_type(cpu_pkg::OP_ADDI, 9, 8, 1), 1'b1, 9, 32'd50);
	endfunction

	function automatic string program_name(int prog);
		case (prog)
			0:       return "alu ops";
			1:       return "random addi";
			2:       return "forwarding";
			3:       return "load store";
			default: return "branches";
		endcase
	endfunction

	//////////////////////////////
	// Drivers and checkers

	task automatic apply_reset();
		rst      = 1'b1;
		enable   = 1'b0;
		load_req = 1'b0;
		repeat (10) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic check_quiet();
		checks++;
		if (retire.valid !== 1'b0) begin
			$display("Error at %0t: a retire appeared while the core was halted", $time);
			errors++;
		end
	endtask

	// One four-phase transfer, entered on a falling edge
	task automatic handshake_word(cpu_pkg::pc_t addr, cpu_pkg::word_t data);
		int waited;
		checks++;
		if (load_ack !== 1'b0) begin
			$display("Error at %0t: load_ack already high before request to %0d", $time, addr);
			errors++;
		end
		load_addr = addr;
		load_data = data;
		load_req  = 1'b1;
		waited    = 0;
		while (load_ack !== 1'b1 && waited < ACK_LIMIT) begin
			@(negedge clk);
			waited++;
			check_quiet();
		end
		if (load_ack !== 1'b1) begin
			$display("Error at %0t: load request to address %0d was never acknowledged",
				$time, addr);
			errors++;
		end
		load_req = 1'b0;                    // Phase three
		waited   = 0;
		while (load_ack !== 1'b0 && waited < ACK_LIMIT) begin
			@(negedge clk);
			waited++;
			check_quiet();
		end
		if (load_ack !== 1'b0) begin
			$display("Error at %0t: load_ack for address %0d stayed high after req dropped",
				$time, addr);
			errors++;
		end
	endtask

	task automatic fill_imem(int prog);
		cpu_pkg::word_t image [cpu_pkg::IMEM_DEPTH];
		int             addr;
		for (addr = 0; addr < cpu_pkg::IMEM_DEPTH; addr++) begin
			image[addr] = cpu_pkg::NOP_INSTR;
		end
		addr = 0;
		foreach (rows[i]) begin
			if (rows[i].prog == prog[2:0]) begin
				image[addr] = rows[i].instr;
				addr++;
			end
		end
		for (addr = 0; addr < cpu_pkg::IMEM_DEPTH; addr++) begin
			handshake_word(addr[6:0], image[addr]);   // Every word, NOPs too
		end
	endtask

	task automatic run_program(int prog);
		row_t expected [$];
		int   n_rows;
		int   seen;
		int   cycles;
		int   limit;
		n_rows = 0;
		foreach (rows[i]) begin
			if (rows[i].prog == prog[2:0]) begin
				n_rows++;
				if (rows[i].ret) expected.push_back(rows[i]);
			end
		end
		limit  = 6 * n_rows + 30;         // Stalls plus pipeline fill
		seen   = 0;
		cycles = 0;
		while (seen < expected.size() && cycles < limit) begin
			@(negedge clk);
			cycles++;
			if (retire.valid === 1'b1) begin
				checks++;
				if (retire.dst !== expected[seen].dst || retire.data !== expected[seen].val) begin
					$display("MISMATCH at %0t: %s retire %0d wrote r%0d = %h, expected r%0d = %h",
						$time, program_name(prog), seen, retire.dst, retire.data,
						expected[seen].dst, expected[seen].val);
					errors++;
				end
				seen++;
			end
		end
		if (seen < expected.size()) begin
			$display("Error at %0t: %s retired only %0d of %0d expected writes",
				$time, program_name(prog), seen, expected.size());
			errors++;
		end
		repeat (TAIL_CYCLES) begin
			@(negedge clk);
			checks++;
			if (retire.valid !== 1'b0) begin
				$display("Error at %0t: %s retired an extra write to r%0d",
					$time, program_name(prog), retire.dst);
				errors++;
			end
		end
	endtask

	// Loader must ignore requests while the core runs
	task automatic probe_load_when_running();
		load_addr = '0;
		load_data = 32'hdead_beef;
		load_req  = 1'b1;
		repeat (6) begin
			@(negedge clk);
			checks++;
			if (load_ack !== 1'b0) begin
				$display("MISMATCH at %0t: load_ack = %b with enable high, expected 0",
					$time, load_ack);
				errors++;
			end
		end
		load_req = 1'b0;
		@(negedge clk);
	endtask

	task automatic report_test(string name, int err_start, int chk_start);
		tests_run++;
		if (errors == err_start) begin
			tests_passed++;
			$display("Test %s: ok, %0d checks", name, checks - chk_start);
		end else begin
			$display("Test %s: failed with %0d errors", name, errors - err_start);
		end
	endtask

	//////////////////////////////
	// Main sequence

	initial begin
		int err_start;
		int chk_start;
		int p;
		rst          = 1'b1;
		enable       = 1'b0;
		load_req     = 1'b0;
		load_addr    = '0;
		load_data    = '0;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_passed = 0;
		build_table();
		table_ready = 1'b1;

		apply_reset();
		err_start = errors;
		chk_start = checks;
		repeat (10) begin
			@(negedge clk);
			checks++;
			if (retire.valid !== 1'b0 || load_ack !== 1'b0) begin
				$display("MISMATCH at %0t: after reset retire.valid = %b, load_ack = %b, expected 0",
					$time, retire.valid, load_ack);
				errors++;
			end
		end
		report_test("reset state", err_start, chk_start);

		for (p = 0; p < N_PROGS; p++) begin
			err_start = errors;
			chk_start = checks;
			apply_reset();
			fill_imem(p);
			enable = 1'b1;                  // Still on a falling edge
			run_program(p);
			if (p == 0) probe_load_when_running();
			enable = 1'b0;
			report_test(program_name(p), err_start, chk_start);
		end

		$display("Tests run %0d, passed %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_passed, tests_run - tests_passed, checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
